// File: Bender.yml
package:
  name: maxflow_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - source/maxflow_pkg.sv
      - source/maxflow_cfg_regs.sv
      - source/graph_mem.sv
      - source/graph_mem_arbiter.sv
      - source/vertex_update_unit.sv
      - source/edge_expand_unit.sv
      - source/maxflow_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - test/clk_gen.sv
      - test/maxflow_tb.sv

// File: maxflow_core.f
+incdir+.
source/maxflow_pkg.sv
source/maxflow_cfg_regs.sv
source/graph_mem.sv
source/graph_mem_arbiter.sv
source/vertex_update_unit.sv
source/edge_expand_unit.sv
source/maxflow_core.sv
test/clk_gen.sv
test/maxflow_tb.sv

// File: maxflow_defines.svh
`ifndef MAXFLOW_DEFINES_SVH
`define MAXFLOW_DEFINES_SVH

// widths
`define MF_VID_W           24
`define MF_DEG_W           4
`define MF_MAX_DEG         10
`define MF_ADDR_W          8
`define MF_REG_ADDR_W      8

// storage depths
`define MF_MEM_DEPTH       256
`define MF_IN_DEPTH        4
`define MF_LINK_DEPTH      2

// out credit counter width
`define MF_CREDIT_W        8

// register byte addresses
`define MF_REG_NUM_V       4
`define MF_REG_BASE_EDGE   16
`define MF_REG_BASE_VERTEX 20
`define MF_REG_SOURCE      28
`define MF_REG_SINK        36

`endif

// File: source/edge_expand_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module edge_expand_unit
   import maxflow_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rstn,
   input  wire cfg_t        cfg,
   input  wire mf_task_t    link_task,
   output logic             link_credit,
   output mem_req_t         mem_req,
   input  wire logic        mem_gnt,
   input  wire vertex_rec_t mem_rdata,
   output mf_task_t         out_task,
   input  wire logic        out_credit
);

   localparam int BPTR_W = $clog2(`MF_LINK_DEPTH);

   typedef enum logic [1:0] {ee_idle, ee_fetch, ee_wait, ee_emit} ee_state_e;

   ee_state_e state;
   mf_task_t lbuf [`MF_LINK_DEPTH];
   logic [BPTR_W-1:0] wr_ptr;
   logic [BPTR_W-1:0] rd_ptr;
   logic [BPTR_W:0] b_count;
   mf_task_t head;
   logic retire;
   logic emit;
   logic phase;
   logic [31:0] idx;
   logic [31:0] idx_next;
   logic [31:0] edge_off;
   edge_rec_t edge_q;
   logic [`MF_CREDIT_W-1:0] out_cnt;

   assign head = lbuf[rd_ptr];
   assign emit = (state == ee_emit) && (out_cnt != '0);
   assign idx_next = idx + 1'b1;

   always_comb begin
      retire = 1'b0;
      if (state == ee_idle) begin
         // discharge with an empty edge list
         retire = (b_count != '0) && (head.kind == kind_discharge)
                  && (head.nbr_height == head.amount);
      end else if (emit) begin
         case (head.kind)
            kind_discharge: retire = (idx_next == head.nbr_height);
            kind_push:      retire = !(!phase && (head.amount > 0) && head.reenq);
            default:        retire = 1'b1;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (link_task.valid) begin
         lbuf[wr_ptr] <= link_task;
      end
      if (state == ee_idle) begin
         idx <= head.amount;
      end else if (emit) begin
         idx <= idx_next;
      end
      if (state == ee_wait) begin
         edge_q <= mem_rdata[$bits(edge_rec_t)-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         b_count <= '0;
         link_credit <= 1'b0;
         out_cnt <= '0;
      end else begin
         if (link_task.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (retire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         b_count <= b_count + {{BPTR_W{1'b0}}, link_task.valid} - {{BPTR_W{1'b0}}, retire};
         link_credit <= retire;
         out_cnt <= out_cnt + {{(`MF_CREDIT_W-1){1'b0}}, out_credit}
                    - {{(`MF_CREDIT_W-1){1'b0}}, emit};
      end
   end

   // sequencer
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ee_idle;
         phase <= 1'b0;
      end else begin
         case (state)
            ee_idle: begin
               phase <= 1'b0;
               if ((b_count != '0) && !retire) begin
                  state <= (head.kind == kind_discharge) ? ee_fetch : ee_emit;
               end
            end
            ee_fetch: begin
               if (mem_gnt) begin
                  state <= ee_wait;
               end
            end
            ee_wait: begin
               state <= ee_emit;
            end
            ee_emit: begin
               if (emit) begin
                  if (retire) begin
                     state <= ee_idle;
                  end else if (head.kind == kind_discharge) begin
                     state <= ee_fetch;
                  end else begin
                     phase <= 1'b1;
                  end
               end
            end
            default: begin
               state <= ee_idle;
            end
         endcase
      end
   end

   always_comb begin
      mem_req.valid = (state == ee_fetch);
      mem_req.write = 1'b0;
      mem_req.addr = cfg.base_edge + mem_addr_t'(idx);
      mem_req.wdata = '0;
   end

   // child task keeps ts
   always_comb begin
      edge_off = idx - head.amount;
      out_task = head;
      out_task.valid = emit;
      out_task.reenq = 1'b0;
      case (head.kind)
         kind_discharge: begin
            out_task.kind = kind_get_height;
            out_task.locale = edge_q.dest;
            out_task.nbr = head.locale;
            out_task.rev_id = edge_q.rev_id;
            out_task.fwd_id = edge_off[`MF_DEG_W-1:0];
            out_task.amount = edge_q.capacity;
            out_task.nbr_height = '0;
         end
         kind_get_height: begin
            out_task.kind = kind_push;
            out_task.locale = head.nbr;
            out_task.nbr = head.locale;
         end
         kind_push: begin
            if (!phase && (head.amount > 0)) begin
               out_task.kind = kind_receive;
               out_task.locale = head.nbr;
            end else begin
               out_task.kind = kind_discharge;
            end
         end
         default: begin
            out_task.kind = kind_discharge;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/graph_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module graph_mem
   import maxflow_pkg::*;
(
   input  wire logic     clk,
   input  wire mem_req_t req,
   output vertex_rec_t   rdata
);

   // vertex and edge regions share the array
   vertex_rec_t mem [`MF_MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (req.valid) begin
         if (req.write) begin
            mem[req.addr] <= req.wdata;
         end else begin
            rdata <= mem[req.addr];
         end
      end
   end

endmodule

`default_nettype wire

// File: source/graph_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module graph_mem_arbiter
   import maxflow_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rstn,
   input  wire mem_req_t host_req,
   input  wire mem_req_t vu_req,
   input  wire mem_req_t ee_req,
   output logic          host_gnt,
   output logic          vu_gnt,
   output logic          ee_gnt,
   output mem_req_t      mem_req
);

   mem_req_t reqs [3];
   logic [1:0] last_q;
   logic [1:0] cand;
   logic [1:0] sel;
   logic found;

   function automatic logic [1:0] next_port(input logic [1:0] p);
      return (p == 2'd2) ? 2'd0 : p + 2'd1;
   endfunction

   assign reqs[0] = host_req;
   assign reqs[1] = vu_req;
   assign reqs[2] = ee_req;

   // search starts one past the last winner
   always_comb begin
      found = 1'b0;
      sel = last_q;
      cand = next_port(last_q);
      for (int i = 0; i < 3; i++) begin
         if (!found && reqs[cand].valid) begin
            found = 1'b1;
            sel = cand;
         end
         cand = next_port(cand);
      end
   end

   always_comb begin
      host_gnt = found && (sel == 2'd0);
      vu_gnt = found && (sel == 2'd1);
      ee_gnt = found && (sel == 2'd2);
      mem_req = found ? reqs[sel] : '0;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_q <= 2'd2;
      end else if (found) begin
         last_q <= sel;
      end
   end

endmodule

`default_nettype wire

// File: source/maxflow_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module maxflow_cfg_regs
   import maxflow_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    rstn,
   input  wire reg_wr_t reg_wr,
   output cfg_t         cfg
);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg <= '0;
      end else if (reg_wr.valid) begin
         case (reg_wr.addr)
            `MF_REG_NUM_V: begin
               cfg.num_v <= reg_wr.wdata[`MF_VID_W-1:0];
            end
            // bases are word addresses into graph_mem
            `MF_REG_BASE_VERTEX: begin
               cfg.base_vertex <= reg_wr.wdata[`MF_ADDR_W-1:0];
            end
            `MF_REG_BASE_EDGE: begin
               cfg.base_edge <= reg_wr.wdata[`MF_ADDR_W-1:0];
            end
            `MF_REG_SOURCE: begin
               cfg.source <= reg_wr.wdata[`MF_VID_W-1:0];
            end
            `MF_REG_SINK: begin
               cfg.sink <= reg_wr.wdata[`MF_VID_W-1:0];
            end
            default: begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/maxflow_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module maxflow_core
   import maxflow_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rstn,
   input  wire reg_wr_t  reg_wr,
   input  wire mf_task_t in_task,
   output logic          in_credit,
   output mf_task_t      out_task,
   input  wire logic     out_credit,
   input  wire mem_req_t host_req,
   output logic          host_gnt,
   output vertex_rec_t   host_rdata
);

   cfg_t cfg;
   mem_req_t vu_req;
   mem_req_t ee_req;
   mem_req_t mem_req;
   logic vu_gnt;
   logic ee_gnt;
   mf_task_t link_task;
   logic link_credit;

   maxflow_cfg_regs cfg_regs_i (
      .clk    (clk),
      .rstn   (rstn),
      .reg_wr (reg_wr),
      .cfg    (cfg)
   );

   graph_mem_arbiter arbiter_i (
      .clk      (clk),
      .rstn     (rstn),
      .host_req (host_req),
      .vu_req   (vu_req),
      .ee_req   (ee_req),
      .host_gnt (host_gnt),
      .vu_gnt   (vu_gnt),
      .ee_gnt   (ee_gnt),
      .mem_req  (mem_req)
   );

   // read data is shared by all three requesters
   graph_mem graph_mem_i (
      .clk   (clk),
      .req   (mem_req),
      .rdata (host_rdata)
   );

   vertex_update_unit vertex_update_i (
      .clk         (clk),
      .rstn        (rstn),
      .cfg         (cfg),
      .in_task     (in_task),
      .in_credit   (in_credit),
      .mem_req     (vu_req),
      .mem_gnt     (vu_gnt),
      .mem_rdata   (host_rdata),
      .link_task   (link_task),
      .link_credit (link_credit)
   );

   edge_expand_unit edge_expand_i (
      .clk         (clk),
      .rstn        (rstn),
      .cfg         (cfg),
      .link_task   (link_task),
      .link_credit (link_credit),
      .mem_req     (ee_req),
      .mem_gnt     (ee_gnt),
      .mem_rdata   (host_rdata),
      .out_task    (out_task),
      .out_credit  (out_credit)
   );

endmodule

`default_nettype wire

// File: source/maxflow_pkg.sv
`default_nettype none
`include "maxflow_defines.svh"

package maxflow_pkg;

   typedef logic [`MF_VID_W-1:0] vid_t;
   typedef logic signed [31:0] flow_t;
   typedef logic [31:0] height_t;
   typedef logic [31:0] ts_t;
   typedef logic [`MF_DEG_W-1:0] edge_idx_t;
   typedef logic [`MF_ADDR_W-1:0] mem_addr_t;

   typedef enum logic [1:0] {
      kind_discharge  = 2'd0,
      kind_get_height = 2'd1,
      kind_push       = 2'd2,
      kind_receive    = 2'd3
   } task_kind_e;

   // one graph memory word
   typedef struct packed {
      logic [31:0] eo_end;
      logic [31:0] eo_begin;
      flow_t [`MF_MAX_DEG-1:0] flow;
      height_t height;
      logic [7:0] counter;
      logic [23:0] min_height;
      flow_t excess;
   } vertex_rec_t;

   // low bits of an edge region word
   typedef struct packed {
      flow_t capacity;
      edge_idx_t rev_id;
      vid_t dest;
   } edge_rec_t;

   typedef struct packed {
      logic valid;
      task_kind_e kind;
      ts_t ts;
      vid_t locale;
      vid_t nbr;
      edge_idx_t rev_id;
      edge_idx_t fwd_id;
      flow_t amount;
      height_t nbr_height;
      logic reenq;
   } mf_task_t;

   typedef struct packed {
      logic valid;
      logic write;
      mem_addr_t addr;
      vertex_rec_t wdata;
   } mem_req_t;

   typedef struct packed {
      vid_t num_v;
      mem_addr_t base_vertex;
      mem_addr_t base_edge;
      vid_t source;
      vid_t sink;
   } cfg_t;

   typedef struct packed {
      logic valid;
      logic [`MF_REG_ADDR_W-1:0] addr;
      logic [31:0] wdata;
   } reg_wr_t;

endpackage

`default_nettype wire

// File: source/vertex_update_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module vertex_update_unit
   import maxflow_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rstn,
   input  wire cfg_t        cfg,
   input  wire mf_task_t    in_task,
   output logic             in_credit,
   output mem_req_t         mem_req,
   input  wire logic        mem_gnt,
   input  wire vertex_rec_t mem_rdata,
   output mf_task_t         link_task,
   input  wire logic        link_credit
);

   localparam int QPTR_W = $clog2(`MF_IN_DEPTH);
   localparam int LCNT_W = $clog2(`MF_LINK_DEPTH + 1);

   typedef enum logic [1:0] {vu_idle, vu_read, vu_modify, vu_write} vu_state_e;

   vu_state_e state;
   mf_task_t queue [`MF_IN_DEPTH];
   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QPTR_W:0] q_count;
   logic q_pop;
   logic [LCNT_W-1:0] link_cnt;
   logic link_send;

   mf_task_t cur;
   mf_task_t fwd;
   mf_task_t fwd_q;
   vertex_rec_t new_rec;
   vertex_rec_t wr_rec;
   logic do_write;
   logic do_fwd;
   logic need_write;
   logic need_fwd;
   flow_t flow_f;
   flow_t resid;
   flow_t amt;
   logic reenq;

   assign q_pop = (state == vu_idle) && (q_count != '0);
   assign link_send = (state == vu_write) && need_fwd && (link_cnt != '0);

   always_ff @(posedge clk) begin
      if (in_task.valid) begin
         queue[wr_ptr] <= in_task;
      end
      if (q_pop) begin
         cur <= queue[rd_ptr];
      end
      if (state == vu_modify) begin
         wr_rec <= new_rec;
         fwd_q <= fwd;
      end
   end

   // one credit back to the host per consumed entry
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_count <= '0;
         in_credit <= 1'b0;
         link_cnt <= LCNT_W'(`MF_LINK_DEPTH);
      end else begin
         if (in_task.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (q_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         q_count <= q_count + {{QPTR_W{1'b0}}, in_task.valid} - {{QPTR_W{1'b0}}, q_pop};
         in_credit <= q_pop;
         link_cnt <= link_cnt + {{(LCNT_W-1){1'b0}}, link_credit}
                     - {{(LCNT_W-1){1'b0}}, link_send};
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= vu_idle;
         need_write <= 1'b0;
         need_fwd <= 1'b0;
      end else begin
         case (state)
            vu_idle: begin
               if (q_pop) begin
                  state <= vu_read;
               end
            end
            vu_read: begin
               if (mem_gnt) begin
                  state <= vu_modify;
               end
            end
            vu_modify: begin
               need_write <= do_write;
               need_fwd <= do_fwd;
               state <= vu_write;
            end
            vu_write: begin
               if (mem_gnt) begin
                  need_write <= 1'b0;
               end
               if (link_send) begin
                  need_fwd <= 1'b0;
               end
               if ((!need_write || mem_gnt) && (!need_fwd || link_send)) begin
                  state <= vu_idle;
               end
            end
            default: begin
               state <= vu_idle;
            end
         endcase
      end
   end

   always_comb begin
      mem_req.valid = (state == vu_read) || ((state == vu_write) && need_write);
      mem_req.write = (state == vu_write);
      mem_req.addr = cfg.base_vertex + mem_addr_t'(cur.locale);
      mem_req.wdata = wr_rec;
      link_task = fwd_q;
      link_task.valid = link_send;
   end

   // record update from the read data in vu_modify
   always_comb begin
      new_rec = mem_rdata;
      fwd = cur;
      do_write = 1'b0;
      do_fwd = 1'b0;
      flow_f = mem_rdata.flow[cur.fwd_id];
      resid = cur.amount - flow_f;
      amt = '0;
      reenq = 1'b0;
      case (cur.kind)
         kind_discharge: begin
            new_rec.counter = 8'(mem_rdata.eo_end - mem_rdata.eo_begin);
            new_rec.min_height = {cfg.num_v[22:0], 1'b0};
            // edge range rides in amount and nbr_height
            fwd.amount = flow_t'(mem_rdata.eo_begin);
            fwd.nbr_height = mem_rdata.eo_end;
            do_write = 1'b1;
            do_fwd = 1'b1;
         end
         kind_get_height: begin
            fwd.nbr_height = mem_rdata.height;
            do_fwd = 1'b1;
         end
         kind_push: begin
            if ((mem_rdata.height == cur.nbr_height + 1'b1) || (cur.locale == cfg.source)) begin
               amt = (mem_rdata.excess > resid) ? resid : mem_rdata.excess;
            end
            if (amt > 0) begin
               new_rec.flow[cur.fwd_id] = flow_f + amt;
               new_rec.excess = mem_rdata.excess - amt;
            end
            new_rec.counter = mem_rdata.counter - 1'b1;
            // candidate for relabel
            if ((resid > amt) && (cur.nbr_height < height_t'(mem_rdata.min_height))) begin
               new_rec.min_height = cur.nbr_height[23:0];
            end
            reenq = (new_rec.counter == '0) && (new_rec.excess > 0);
            if (reenq) begin
               new_rec.height = height_t'(new_rec.min_height) + 1'b1;
            end
            fwd.amount = amt;
            fwd.reenq = reenq;
            do_write = 1'b1;
            do_fwd = (amt > 0) || reenq;
         end
         default: begin
            new_rec.excess = mem_rdata.excess + cur.amount;
            new_rec.flow[cur.rev_id] = flow_t'(mem_rdata.flow[cur.rev_id]) - cur.amount;
            do_write = 1'b1;
            do_fwd = (mem_rdata.excess == 0) && (cur.locale != cfg.source)
                     && (cur.locale != cfg.sink);
         end
      endcase
   end

endmodule

`default_nettype wire

// File: test/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
   output logic clk,
   output logic rstn
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
   end

endmodule

`default_nettype wire

// File: test/maxflow_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "maxflow_defines.svh"

module maxflow_tb
   import maxflow_pkg::*;
;

   localparam int MAX_CYCLES = 4000;
   localparam int VERTEX_BASE = 32;

   logic clk;
   logic rstn;
   reg_wr_t reg_wr;
   mf_task_t in_task;
   logic in_credit;
   mf_task_t out_task;
   logic out_credit;
   mem_req_t host_req;
   logic host_gnt;
   vertex_rec_t host_rdata;

   mf_task_t out_q [$];
   int credit_returns;
   int sent;
   int cycles;
   int errors;
   logic [31:0] lfsr;
   vid_t num_v;
   vid_t sink;
   height_t h_get;

   clk_gen clk_gen_i (
      .clk  (clk),
      .rstn (rstn)
   );

   maxflow_core maxflow_core_i (
      .clk        (clk),
      .rstn       (rstn),
      .reg_wr     (reg_wr),
      .in_task    (in_task),
      .in_credit  (in_credit),
      .out_task   (out_task),
      .out_credit (out_credit),
      .host_req   (host_req),
      .host_gnt   (host_gnt),
      .host_rdata (host_rdata)
   );

   initial begin
      reg_wr = '0;
      in_task = '0;
      out_credit = 1'b0;
      host_req = '0;
   end

   // outputs and returned credits sampled away from the active edge
   always @(negedge clk) begin
      if (rstn && out_task.valid) begin
         out_q.push_back(out_task);
      end
      if (rstn && in_credit) begin
         credit_returns++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Something failed");
         $fatal(1);
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic mem_addr_t vertex_addr(input vid_t v);
      return mem_addr_t'(VERTEX_BASE + v);
   endfunction

   function automatic vertex_rec_t build_vertex(input logic [31:0] eb, input logic [31:0] ee,
                                                input height_t h, input logic [7:0] cnt,
                                                input logic [23:0] mh, input flow_t ex);
      vertex_rec_t v;
      v = '0;
      v.eo_begin = eb;
      v.eo_end = ee;
      v.height = h;
      v.counter = cnt;
      v.min_height = mh;
      v.excess = ex;
      return v;
   endfunction

   function automatic mf_task_t build_task(input task_kind_e k, input ts_t ts, input vid_t loc,
                                           input vid_t nbr, input edge_idx_t rev,
                                           input edge_idx_t fwd, input flow_t amt,
                                           input height_t nh);
      mf_task_t t;
      t = '0;
      t.valid = 1'b1;
      t.kind = k;
      t.ts = ts;
      t.locale = loc;
      t.nbr = nbr;
      t.rev_id = rev;
      t.fwd_id = fwd;
      t.amount = amt;
      t.nbr_height = nh;
      return t;
   endfunction

   task automatic check(input logic ok, input string msg);
      assert (ok) else begin
         errors++;
         $display("Fail at %0t ns: %s", $time, msg);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      reg_wr_t w;
      w.valid = 1'b1;
      w.addr = addr;
      w.wdata = data;
      @(posedge clk);
      reg_wr <= w;
      @(posedge clk);
      reg_wr <= '0;
   endtask

   // request stays up until the arbiter grants it
   task automatic mem_access(input logic wr, input mem_addr_t addr, input vertex_rec_t wdata,
                             output vertex_rec_t rdata);
      mem_req_t r;
      r.valid = 1'b1;
      r.write = wr;
      r.addr = addr;
      r.wdata = wdata;
      @(posedge clk);
      host_req <= r;
      @(negedge clk);
      while (!host_gnt) @(negedge clk);
      @(posedge clk);
      host_req <= '0;
      @(negedge clk);
      rdata = host_rdata;
   endtask

   task automatic write_word(input mem_addr_t addr, input vertex_rec_t d);
      vertex_rec_t unused;
      mem_access(1'b1, addr, d, unused);
   endtask

   task automatic read_word(input mem_addr_t addr, output vertex_rec_t d);
      mem_access(1'b0, addr, '0, d);
   endtask

   task automatic send_task(input mf_task_t t);
      while (`MF_IN_DEPTH + credit_returns - sent == 0) @(negedge clk);
      @(posedge clk);
      in_task <= t;
      sent++;
      @(posedge clk);
      in_task <= '0;
   endtask

   task automatic give_credits(input int n);
      repeat (n) begin
         @(posedge clk);
         out_credit <= 1'b1;
         @(posedge clk);
         out_credit <= 1'b0;
      end
   endtask

   task automatic wait_outputs(input int n);
      while (out_q.size() < n) @(negedge clk);
   endtask

   task automatic settle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic config_and_memory_load();
      vertex_rec_t wr_data [8];
      vertex_rec_t rd;
      num_v = 8;
      sink = 7;
      write_reg(`MF_REG_NUM_V, 32'(num_v));
      write_reg(`MF_REG_BASE_VERTEX, 32'(VERTEX_BASE));
      write_reg(`MF_REG_BASE_EDGE, 32'd128);
      write_reg(`MF_REG_SOURCE, 32'd0);
      write_reg(`MF_REG_SINK, 32'(sink));
      for (int i = 0; i < 8; i++) begin
         for (int w = 0; w < $bits(vertex_rec_t) / 32; w++) begin
            wr_data[i][w*32 +: 32] = rand_bits(32);
         end
         write_word(mem_addr_t'(200 + i), wr_data[i]);
      end
      for (int i = 0; i < 8; i++) begin
         read_word(mem_addr_t'(200 + i), rd);
         check(rd == wr_data[i], $sformatf("readback mismatch at word %0d", 200 + i));
      end
   endtask

   task automatic get_height_yields_push();
      mf_task_t o;
      h_get = 32'(rand_bits(6)) + 1;
      write_word(vertex_addr(3), build_vertex(0, 0, h_get, 0, 0, 0));
      give_credits(1);
      send_task(build_task(kind_get_height, 32'd11, 3, 5, 2, 1, 40, 0));
      wait_outputs(1);
      o = out_q.pop_front();
      check(o.kind == kind_push, "get_height child is not a push");
      check(o.locale == 5 && o.nbr == 3, "push locale or nbr wrong");
      check(o.nbr_height == h_get, "push does not carry the height");
      check(o.ts == 32'd11 && o.fwd_id == 1 && o.rev_id == 2, "push arguments wrong");
      check(o.amount == 40, "push amount wrong");
   endtask

   task automatic discharge_expands_edges();
      vid_t dest [3] = '{2, 3, 6};
      flow_t cap [3];
      edge_idx_t rev [3];
      edge_rec_t e;
      vertex_rec_t w;
      vertex_rec_t rd;
      mf_task_t o;
      write_word(vertex_addr(1), build_vertex(4, 7, 3, 0, 0, 20));
      for (int i = 0; i < 3; i++) begin
         cap[i] = flow_t'(rand_bits(12)) + 1;
         rev[i] = edge_idx_t'(rand_bits(3));
         e.capacity = cap[i];
         e.rev_id = rev[i];
         e.dest = dest[i];
         w = '0;
         w[$bits(edge_rec_t)-1:0] = e;
         write_word(mem_addr_t'(128 + 4 + i), w);
      end
      give_credits(3);
      send_task(build_task(kind_discharge, 32'd21, 1, 0, 0, 0, 0, 0));
      wait_outputs(3);
      for (int i = 0; i < 3; i++) begin
         o = out_q.pop_front();
         check(o.kind == kind_get_height, $sformatf("child %0d is not get_height", i));
         check(o.locale == dest[i] && o.nbr == 1, $sformatf("child %0d dest wrong", i));
         check(o.rev_id == rev[i] && o.fwd_id == edge_idx_t'(i),
               $sformatf("child %0d edge ids wrong", i));
         check(o.amount == cap[i] && o.ts == 32'd21, $sformatf("child %0d capacity wrong", i));
      end
      settle(10);
      read_word(vertex_addr(1), rd);
      check(rd.counter == 8'd3, "discharge counter not 3");
      check(rd.min_height == 24'(2 * num_v), "discharge min_height not twice num_v");
   endtask

   task automatic push_and_relabel();
      flow_t cap;
      flow_t ex;
      vertex_rec_t rd;
      mf_task_t o;
      // excess above capacity so the amount clamps to capacity
      cap = flow_t'(rand_bits(6)) + 1;
      ex = cap + flow_t'(rand_bits(6)) + 1;
      write_word(vertex_addr(2), build_vertex(0, 3, 5, 3, 16, ex));
      give_credits(1);
      send_task(build_task(kind_push, 32'd31, 2, 4, 0, 1, cap, 4));
      wait_outputs(1);
      o = out_q.pop_front();
      check(o.kind == kind_receive && o.locale == 4, "admissible push gave no receive to nbr");
      check(o.amount == cap && o.ts == 32'd31, "receive amount not clamped");
      settle(10);
      read_word(vertex_addr(2), rd);
      check(rd.flow[1] == cap && rd.excess == ex - cap, "push flow or excess wrong");
      // no residual left, min_height stays
      check(rd.counter == 8'd2 && rd.min_height == 24'd16, "push counter or min_height wrong");
      // last push with heights not admissible
      write_word(vertex_addr(5), build_vertex(0, 1, 9, 1, 16, 30));
      give_credits(1);
      send_task(build_task(kind_push, 32'd32, 5, 4, 0, 0, 12, 3));
      wait_outputs(1);
      o = out_q.pop_front();
      check(o.kind == kind_discharge && o.locale == 5, "relabel gave no discharge to itself");
      settle(10);
      read_word(vertex_addr(5), rd);
      check(rd.min_height == 24'd3 && rd.height == 32'd4, "relabel height wrong");
      check(out_q.size() == 0, "extra output after push");
   endtask

   task automatic receive_at_vertex_and_sink();
      flow_t amt;
      vertex_rec_t rd;
      mf_task_t o;
      amt = flow_t'(rand_bits(8)) + 1;
      write_word(vertex_addr(6), build_vertex(0, 0, 2, 0, 0, 0));
      write_word(vertex_addr(sink), build_vertex(0, 0, 0, 0, 0, 0));
      // a credit is available so a wrong child of the sink would show up
      give_credits(1);
      send_task(build_task(kind_receive, 32'd42, sink, sink, 0, 0, amt, 0));
      while (credit_returns < sent) @(negedge clk);
      settle(10);
      check(out_q.size() == 0, "receive at sink gave an output");
      read_word(vertex_addr(sink), rd);
      check(rd.excess == amt, "sink excess did not grow");
      send_task(build_task(kind_receive, 32'd41, 6, 6, 2, 0, amt, 0));
      wait_outputs(1);
      o = out_q.pop_front();
      check(o.kind == kind_discharge && o.locale == 6, "receive gave no discharge");
      check(o.ts == 32'd41, "receive child ts wrong");
      settle(10);
      read_word(vertex_addr(6), rd);
      check(rd.excess == amt && rd.flow[2] == -amt, "receive excess or flow wrong");
   endtask

   task automatic back_pressure();
      mf_task_t o;
      int gap;
      for (int i = 0; i < 6; i++) begin
         send_task(build_task(kind_get_height, 32'(100 + i), 3, vid_t'(10 + i), 0, 0, 0, 0));
      end
      settle(30);
      check(out_q.size() == 0, "output appeared without credit");
      for (int i = 0; i < 6; i++) begin
         gap = int'(rand_bits(3));
         settle(gap);
         give_credits(1);
         wait_outputs(1);
         settle(6);
         check(out_q.size() == 1, "one credit released more than one task");
         o = out_q.pop_front();
         check(o.kind == kind_push && o.locale == vid_t'(10 + i), "released task out of order");
         check(o.nbr_height == h_get && o.ts == 32'(100 + i), "released task fields wrong");
      end
      while (credit_returns < sent) @(negedge clk);
      settle(6);
      check(credit_returns == sent, "input credit pulses differ from tasks sent");
   endtask

   initial begin
      lfsr = 32'he73e_2b5d;
      credit_returns = 0;
      sent = 0;
      cycles = 0;
      errors = 0;
      wait (rstn === 1'b1);
      @(negedge clk);
      check(!in_credit && !out_task.valid && !host_gnt, "outputs not low after reset");
      config_and_memory_load();
      get_height_yields_push();
      discharge_expands_edges();
      push_and_relabel();
      receive_at_vertex_and_sink();
      back_pressure();
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
